// File: hw/cache_pkg.sv
package cache_pkg;

    localparam int ADDR_WIDTH = 32;
    localparam int WORD_WIDTH = 32;
    localparam int WORDS_PER_LINE = 4;
    localparam int OFFSET_WIDTH = 4; // Byte offset within a line
    localparam int NUM_WAYS = 4; // PLRU tree below is built for four ways

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [WORD_WIDTH-1:0] word_t;

    // Word k sits at bits 32k+31:32k
    typedef logic [WORD_WIDTH*WORDS_PER_LINE-1:0] line_t;

    typedef logic [1:0] way_t;

    // Bit 2 is the root, bit 1 splits ways 0/1, bit 0 splits ways 2/3
    typedef logic [2:0] plru_t;

    // Memory command encodings
    localparam logic cmd_write = 1'b0;
    localparam logic cmd_read = 1'b1;

    typedef enum logic [2:0] {
        st_idle,
        st_compare,
        st_write_back,
        st_refill_req,
        st_refill_wait,
        st_done
    } ctrl_state_t;

endpackage

// File: hw/cache_set_ram.sv
module cache_set_ram #(
    parameter int NUM_SETS = 128,
    parameter type entry_t = cache_pkg::line_t,
    localparam int INDEX_WIDTH = $clog2(NUM_SETS)
) (
    input logic clk,
    input logic [INDEX_WIDTH-1:0] rd_index,
    input logic [INDEX_WIDTH-1:0] wr_index,
    input logic we,
    input entry_t wdata,
    output entry_t rdata
);

    entry_t mem [NUM_SETS];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_index] <= wdata;
        end
        rdata <= mem[rd_index]; // Old data on a same-set write
    end

endmodule

// File: hw/cache_set_state.sv
module cache_set_state #(
    parameter int NUM_SETS = 128,
    localparam int INDEX_WIDTH = $clog2(NUM_SETS)
) (
    input logic clk,
    input logic reset_n,
    input logic [INDEX_WIDTH-1:0] index,
    output logic [cache_pkg::NUM_WAYS-1:0] valid,
    output logic [cache_pkg::NUM_WAYS-1:0] dirty,
    output cache_pkg::way_t victim_way,
    output logic victim_dirty,
    input logic touch_en,
    input logic fill_en,
    input logic fill_dirty,
    input cache_pkg::way_t access_way
);

    logic [cache_pkg::NUM_WAYS-1:0] valid_r [NUM_SETS];
    logic [cache_pkg::NUM_WAYS-1:0] dirty_r [NUM_SETS];
    cache_pkg::plru_t plru_r [NUM_SETS];

    // Point the tree away from the way just used
    function automatic cache_pkg::plru_t plru_touch(cache_pkg::plru_t p, cache_pkg::way_t way);
        cache_pkg::plru_t n;
        n = p;
        case (way)
            2'd0: n[2:1] = 2'b11;
            2'd1: n[2:1] = 2'b10;
            2'd2: {n[2], n[0]} = 2'b01;
            default: {n[2], n[0]} = 2'b00;
        endcase
        return n;
    endfunction

    function automatic cache_pkg::way_t pick_victim(logic [cache_pkg::NUM_WAYS-1:0] v,
                                                    cache_pkg::plru_t p);
        cache_pkg::way_t way;
        if (p[2]) begin
            way = p[0] ? 2'd3 : 2'd2;
        end else begin
            way = p[1] ? 2'd1 : 2'd0;
        end
        for (int w = cache_pkg::NUM_WAYS - 1; w >= 0; w--) begin
            if (!v[w]) begin
                way = cache_pkg::way_t'(w); // Lowest invalid way wins
            end
        end
        return way;
    endfunction

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid_r[s] <= '0;
                dirty_r[s] <= '0;
                plru_r[s] <= '0;
            end
        end else if (fill_en) begin
            valid_r[index][access_way] <= 1'b1;
            dirty_r[index][access_way] <= fill_dirty;
            plru_r[index] <= plru_touch(plru_r[index], access_way);
        end else if (touch_en) begin
            if (fill_dirty) begin
                dirty_r[index][access_way] <= 1'b1; // Write hit
            end
            plru_r[index] <= plru_touch(plru_r[index], access_way);
        end
    end

    always_ff @(posedge clk) begin
        valid <= valid_r[index];
        dirty <= dirty_r[index];
        victim_way <= pick_victim(valid_r[index], plru_r[index]);
    end

    assign victim_dirty = valid[victim_way] & dirty[victim_way];

    a_fill_touch_excl: assert property (@(posedge clk) disable iff (!reset_n)
        !(fill_en && touch_en));

endmodule

// File: hw/cache_lookup.sv
module cache_lookup #(
    parameter int NUM_SETS = 128,
    localparam int INDEX_WIDTH = $clog2(NUM_SETS),
    localparam int TAG_WIDTH = cache_pkg::ADDR_WIDTH - INDEX_WIDTH - cache_pkg::OFFSET_WIDTH
) (
    input logic [TAG_WIDTH-1:0] tag_q,
    input logic [1:0] word_sel,
    input cache_pkg::word_t wr_word,
    input logic [cache_pkg::NUM_WAYS-1:0] valid,
    input logic [TAG_WIDTH-1:0] way_tags [cache_pkg::NUM_WAYS],
    input cache_pkg::line_t way_lines [cache_pkg::NUM_WAYS],
    input cache_pkg::way_t victim_way,
    input cache_pkg::line_t mem_rsp_data,
    output logic hit,
    output cache_pkg::way_t hit_way,
    output cache_pkg::word_t hit_word,
    output cache_pkg::line_t merged_hit_line,
    output cache_pkg::line_t merged_fill_line,
    output cache_pkg::line_t victim_line,
    output logic [TAG_WIDTH-1:0] victim_tag
);

    localparam int WW = cache_pkg::WORD_WIDTH;

    logic [cache_pkg::NUM_WAYS-1:0] hit_vec;

    function automatic cache_pkg::line_t merge_word(cache_pkg::line_t line, logic [1:0] sel,
                                                    cache_pkg::word_t w);
        cache_pkg::line_t result;
        result = line;
        result[int'(sel)*WW +: WW] = w;
        return result;
    endfunction

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < cache_pkg::NUM_WAYS; w++) begin
            hit_vec[w] = valid[w] && (way_tags[w] == tag_q);
            if (hit_vec[w]) begin
                hit_way = cache_pkg::way_t'(w);
            end
        end
    end

    assign hit = |hit_vec;
    assign hit_word = way_lines[hit_way][int'(word_sel)*WW +: WW];
    assign merged_hit_line = merge_word(way_lines[hit_way], word_sel, wr_word);
    assign merged_fill_line = merge_word(mem_rsp_data, word_sel, wr_word);
    assign victim_line = way_lines[victim_way];
    assign victim_tag = way_tags[victim_way];

    // A tag may live in only one way of a set
    always_comb begin
        if (!$isunknown(hit_vec)) begin
            a_single_hit: assert final ($onehot0(hit_vec));
        end
    end

endmodule

// File: hw/cache_ctrl.sv
module cache_ctrl #(
    parameter int NUM_SETS = 128,
    localparam int INDEX_WIDTH = $clog2(NUM_SETS),
    localparam int TAG_WIDTH = cache_pkg::ADDR_WIDTH - INDEX_WIDTH - cache_pkg::OFFSET_WIDTH
) (
    input logic clk,
    input logic reset_n,
    input logic rd_req,
    input logic wr_req,
    input cache_pkg::addr_t addr,
    input cache_pkg::word_t wr_data,
    output logic req_rdy,
    output cache_pkg::word_t read_data,
    output logic mem_req_en,
    output logic mem_req_cmd,
    output cache_pkg::addr_t mem_req_addr,
    output cache_pkg::line_t mem_req_data,
    input logic mem_req_rdy,
    input logic mem_rsp_en,
    input cache_pkg::line_t mem_rsp_data,
    output logic [INDEX_WIDTH-1:0] set_index,
    output logic [TAG_WIDTH-1:0] tag_q,
    output logic [1:0] word_sel,
    output cache_pkg::word_t wr_word,
    input logic hit,
    input cache_pkg::way_t hit_way,
    input cache_pkg::word_t hit_word,
    input cache_pkg::line_t merged_hit_line,
    input cache_pkg::line_t merged_fill_line,
    input logic [TAG_WIDTH-1:0] way_tags [cache_pkg::NUM_WAYS],
    input cache_pkg::line_t way_lines [cache_pkg::NUM_WAYS],
    input cache_pkg::line_t victim_line,
    input logic [TAG_WIDTH-1:0] victim_tag,
    input cache_pkg::way_t victim_way,
    input logic victim_dirty,
    output logic [cache_pkg::NUM_WAYS-1:0] line_we,
    output cache_pkg::line_t line_wdata,
    output logic [cache_pkg::NUM_WAYS-1:0] tag_we,
    output logic touch_en,
    output logic fill_en,
    output logic fill_dirty,
    output cache_pkg::way_t access_way
);

    localparam int WW = cache_pkg::WORD_WIDTH;
    localparam int OW = cache_pkg::OFFSET_WIDTH;

    cache_pkg::ctrl_state_t state;
    logic [INDEX_WIDTH-1:0] index_q;
    logic is_write_q;
    cache_pkg::addr_t refill_addr;
    cache_pkg::addr_t wb_addr;
    cache_pkg::word_t rsp_word;

    assign req_rdy = (state == cache_pkg::st_idle);

    // RAMs see the incoming index so tags are ready in compare
    assign set_index = req_rdy ? addr[OW +: INDEX_WIDTH] : index_q;

    assign refill_addr = {tag_q, index_q, {OW{1'b0}}};
    assign wb_addr = {victim_tag, index_q, {OW{1'b0}}};
    assign rsp_word = mem_rsp_data[int'(word_sel)*WW +: WW];
    assign fill_dirty = is_write_q; // Also marks a write hit dirty

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state <= cache_pkg::st_idle;
            mem_req_en <= 1'b0;
        end else begin
            case (state)
                cache_pkg::st_idle: begin
                    if (rd_req || wr_req) begin
                        state <= cache_pkg::st_compare;
                    end
                end
                cache_pkg::st_compare: begin
                    if (hit) begin
                        state <= cache_pkg::st_done;
                    end else begin
                        mem_req_en <= 1'b1;
                        state <= victim_dirty ? cache_pkg::st_write_back
                                              : cache_pkg::st_refill_req;
                    end
                end
                cache_pkg::st_write_back: begin
                    if (mem_req_rdy) begin
                        state <= cache_pkg::st_refill_req; // en stays high
                    end
                end
                cache_pkg::st_refill_req: begin
                    if (mem_req_rdy) begin
                        mem_req_en <= 1'b0;
                        state <= cache_pkg::st_refill_wait;
                    end
                end
                cache_pkg::st_refill_wait: begin
                    if (mem_rsp_en) begin
                        state <= cache_pkg::st_done;
                    end
                end
                default: begin
                    state <= cache_pkg::st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            cache_pkg::st_idle: begin
                if (rd_req || wr_req) begin
                    index_q <= addr[OW +: INDEX_WIDTH];
                    tag_q <= addr[cache_pkg::ADDR_WIDTH-1 -: TAG_WIDTH];
                    word_sel <= addr[OW-1 -: 2];
                    wr_word <= wr_data;
                    is_write_q <= wr_req;
                end
            end
            cache_pkg::st_compare: begin
                if (hit) begin
                    if (!is_write_q) begin
                        read_data <= hit_word;
                    end
                end else if (victim_dirty) begin
                    mem_req_cmd <= cache_pkg::cmd_write;
                    mem_req_addr <= wb_addr;
                    mem_req_data <= victim_line;
                end else begin
                    mem_req_cmd <= cache_pkg::cmd_read;
                    mem_req_addr <= refill_addr;
                    mem_req_data <= '0;
                end
            end
            cache_pkg::st_write_back: begin
                if (mem_req_rdy) begin
                    mem_req_cmd <= cache_pkg::cmd_read;
                    mem_req_addr <= refill_addr;
                    mem_req_data <= '0;
                end
            end
            cache_pkg::st_refill_wait: begin
                if (mem_rsp_en && !is_write_q) begin
                    read_data <= rsp_word;
                end
            end
            default: ;
        endcase
    end

    always_comb begin
        line_we = '0;
        tag_we = '0;
        touch_en = 1'b0;
        fill_en = 1'b0;
        access_way = victim_way;
        line_wdata = merged_hit_line;
        if (state == cache_pkg::st_compare && hit) begin
            touch_en = 1'b1;
            access_way = hit_way;
            line_we[hit_way] = is_write_q;
        end
        if (state == cache_pkg::st_refill_wait && mem_rsp_en) begin
            fill_en = 1'b1;
            line_we[victim_way] = 1'b1;
            tag_we[victim_way] = 1'b1;
            line_wdata = is_write_q ? merged_fill_line : mem_rsp_data;
        end
    end

    a_no_strobe_busy: assert property (@(posedge clk) disable iff (!reset_n)
        (rd_req || wr_req) |-> req_rdy);

    a_req_stable: assert property (@(posedge clk) disable iff (!reset_n)
        (mem_req_en && !mem_req_rdy) |=> mem_req_en &&
            $stable({mem_req_cmd, mem_req_addr, mem_req_data}));

endmodule

// File: hw/cache_top.sv
module cache_top #(
    parameter int NUM_SETS = 128,
    localparam int INDEX_WIDTH = $clog2(NUM_SETS),
    localparam int TAG_WIDTH = cache_pkg::ADDR_WIDTH - INDEX_WIDTH - cache_pkg::OFFSET_WIDTH
) (
    input logic clk,
    input logic reset_n,
    input logic rd_req,
    input logic wr_req,
    input cache_pkg::addr_t addr,
    input cache_pkg::word_t wr_data,
    output logic req_rdy,
    output cache_pkg::word_t read_data,
    output logic mem_req_en,
    output logic mem_req_cmd,
    output cache_pkg::addr_t mem_req_addr,
    output cache_pkg::line_t mem_req_data,
    input logic mem_req_rdy,
    input logic mem_rsp_en,
    input cache_pkg::line_t mem_rsp_data
);

    typedef logic [TAG_WIDTH-1:0] tag_t;

    logic [INDEX_WIDTH-1:0] set_index;
    tag_t tag_q;
    logic [1:0] word_sel;
    cache_pkg::word_t wr_word;
    logic hit;
    cache_pkg::way_t hit_way;
    cache_pkg::word_t hit_word;
    cache_pkg::line_t merged_hit_line;
    cache_pkg::line_t merged_fill_line;
    cache_pkg::line_t victim_line;
    tag_t victim_tag;
    tag_t way_tags [cache_pkg::NUM_WAYS];
    cache_pkg::line_t way_lines [cache_pkg::NUM_WAYS];
    logic [cache_pkg::NUM_WAYS-1:0] valid;
    cache_pkg::way_t victim_way;
    logic victim_dirty;
    logic [cache_pkg::NUM_WAYS-1:0] line_we;
    logic [cache_pkg::NUM_WAYS-1:0] tag_we;
    cache_pkg::line_t line_wdata;
    logic touch_en;
    logic fill_en;
    logic fill_dirty;
    cache_pkg::way_t access_way;

    cache_ctrl #(.NUM_SETS(NUM_SETS)) u_ctrl (.*);

    cache_lookup #(.NUM_SETS(NUM_SETS)) u_lookup (
        .tag_q, .word_sel, .wr_word, .valid, .way_tags, .way_lines, .victim_way,
        .mem_rsp_data, .hit, .hit_way, .hit_word, .merged_hit_line, .merged_fill_line,
        .victim_line, .victim_tag
    );

    cache_set_state #(.NUM_SETS(NUM_SETS)) u_set_state (
        .clk, .reset_n, .index(set_index), .valid, .dirty(), .victim_way, .victim_dirty,
        .touch_en, .fill_en, .fill_dirty, .access_way
    );

    for (genvar w = 0; w < cache_pkg::NUM_WAYS; w++) begin : g_way
        cache_set_ram #(.NUM_SETS(NUM_SETS), .entry_t(cache_pkg::line_t)) u_line_ram (
            .clk,
            .rd_index(set_index),
            .wr_index(set_index),
            .we(line_we[w]),
            .wdata(line_wdata),
            .rdata(way_lines[w])
        );

        cache_set_ram #(.NUM_SETS(NUM_SETS), .entry_t(tag_t)) u_tag_ram (
            .clk,
            .rd_index(set_index),
            .wr_index(set_index),
            .we(tag_we[w]),
            .wdata(tag_q), // Only refills write a tag
            .rdata(way_tags[w])
        );
    end

endmodule

// File: tb/mem_model.sv
module mem_model #(
    parameter cache_pkg::word_t FILL_KEY = 32'h0
) (
    input logic clk,
    input logic reset_n,
    input logic stall_en,
    input logic mem_req_en,
    input logic mem_req_cmd,
    input cache_pkg::addr_t mem_req_addr,
    input cache_pkg::line_t mem_req_data,
    output logic mem_req_rdy,
    output logic mem_rsp_en,
    output cache_pkg::line_t mem_rsp_data
);

    cache_pkg::line_t lines [cache_pkg::addr_t];
    logic log_cmd [$];
    cache_pkg::addr_t log_addr [$];
    cache_pkg::line_t log_data [$];

    // Untouched words read back as their address XOR the key
    function automatic cache_pkg::line_t read_line(cache_pkg::addr_t a);
        cache_pkg::line_t l;
        if (lines.exists(a)) begin
            return lines[a];
        end
        for (int k = 0; k < cache_pkg::WORDS_PER_LINE; k++) begin
            l[k*32 +: 32] = (a + cache_pkg::addr_t'(4 * k)) ^ FILL_KEY;
        end
        return l;
    endfunction

    initial begin
        integer seed;
        logic take;
        logic pending;
        int delay;
        cache_pkg::addr_t rsp_addr;
        logic c;
        cache_pkg::addr_t a;
        cache_pkg::line_t d;
        seed = 57435;
        pending = 1'b0;
        delay = 0;
        rsp_addr = '0;
        mem_req_rdy = 1'b0;
        mem_rsp_en = 1'b0;
        mem_rsp_data = '0;
        forever begin
            @(posedge clk);
            take = reset_n && mem_req_en && mem_req_rdy;
            c = mem_req_cmd;
            a = mem_req_addr;
            d = mem_req_data;
            #1;
            mem_rsp_en = 1'b0;
            if (take) begin
                log_cmd.push_back(c);
                log_addr.push_back(a);
                log_data.push_back(d);
                if (c == cache_pkg::cmd_write) begin
                    lines[a] = d;
                end else begin
                    pending = 1'b1;
                    rsp_addr = a;
                    delay = stall_en ? ($random(seed) & 7) : 0;
                end
            end else if (pending) begin
                if (delay == 0) begin
                    mem_rsp_en = 1'b1;
                    mem_rsp_data = read_line(rsp_addr);
                    pending = 1'b0;
                end else begin
                    delay--;
                end
            end
            mem_req_rdy = !stall_en || (($random(seed) & 3) != 0); // Stall about a quarter
        end
    end

endmodule

// File: tb/cache_tb.sv
module cache_tb;

    localparam cache_pkg::word_t FILL_KEY = 32'h5A3C_96E1;
    localparam int TIMEOUT = 2000;

    logic clk, reset_n, rd_req, wr_req, req_rdy, stall_en;
    cache_pkg::addr_t addr, mem_req_addr;
    cache_pkg::word_t wr_data, read_data;
    logic mem_req_en, mem_req_cmd, mem_req_rdy, mem_rsp_en;
    cache_pkg::line_t mem_req_data, mem_rsp_data;

    int errors = 0;
    int test_errors = 0;
    int tests_failed = 0;
    int log_base = 0;
    integer seed = 57435;
    cache_pkg::word_t ref_mem [cache_pkg::addr_t];
    logic m_valid [4];
    logic m_dirty [4];
    cache_pkg::addr_t m_line [4];
    logic [2:0] m_plru; // b2 b1 b0

    cache_top #(.NUM_SETS(128)) uut (.*);

    mem_model #(.FILL_KEY(FILL_KEY)) mem (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic cache_pkg::word_t expect_word(cache_pkg::addr_t a);
        return ref_mem.exists(a) ? ref_mem[a] : (a ^ FILL_KEY);
    endfunction

    function automatic cache_pkg::line_t expect_line(cache_pkg::addr_t a);
        cache_pkg::line_t l;
        for (int k = 0; k < 4; k++) begin
            l[k*32 +: 32] = expect_word(a + cache_pkg::addr_t'(4 * k));
        end
        return l;
    endfunction

    task automatic check_value(string name, logic [127:0] got, logic [127:0] exp);
        assert (got === exp) else begin
            $display("MISMATCH %s: got %0h expected %0h", name, got, exp);
            test_errors++;
        end
    endtask

    task automatic check_request(int idx, logic cmd, cache_pkg::addr_t a);
        assert (mem.log_cmd.size() > log_base + idx) else begin
            $display("Memory request %0d was never issued", idx);
            test_errors++;
        end
        if (mem.log_cmd.size() > log_base + idx) begin
            check_value("mem_req_cmd", mem.log_cmd[log_base+idx], cmd);
            check_value("mem_req_addr", mem.log_addr[log_base+idx], a);
        end
    endtask

    task automatic check_request_count(int n);
        assert (mem.log_cmd.size() - log_base == n) else begin
            $display("Expected %0d memory requests but saw %0d", n,
                     mem.log_cmd.size() - log_base);
            test_errors++;
        end
    endtask

    task automatic run_access(bit write, cache_pkg::addr_t a, cache_pkg::word_t d,
                              output int cycles);
        int guard;
        assert (req_rdy === 1'b1) else begin
            $display("Cache not ready when an access was due");
            test_errors++;
        end
        addr = a;
        wr_data = d;
        rd_req = !write;
        wr_req = write;
        @(posedge clk);
        #2;
        rd_req = 1'b0;
        wr_req = 1'b0;
        cycles = 1;
        guard = 0;
        while (req_rdy !== 1'b1) begin
            if (guard == TIMEOUT) begin
                $display("Timeout waiting for req_rdy, controller in %s",
                         uut.u_ctrl.state.name());
                $display("ERRORS FOUND");
                $finish;
            end else begin
                @(posedge clk);
                #2;
                cycles++;
                guard++;
            end
        end
        if (write) begin
            ref_mem[a] = d;
        end
    endtask

    task automatic read_check(cache_pkg::addr_t a);
        int cycles;
        run_access(1'b0, a, '0, cycles);
        check_value("read_data", read_data, expect_word(a));
    endtask

    task automatic finish_test(string name);
        $display("%s: %s (%0d errors)", name, test_errors == 0 ? "pass" : "fail", test_errors);
        if (test_errors != 0) begin
            tests_failed++;
        end
        errors += test_errors;
        test_errors = 0;
    endtask

    // Same-set replacement model used to predict the victim
    task automatic model_access(bit write, cache_pkg::addr_t line_a,
                                output bit wb, output cache_pkg::addr_t evict_a);
        int w;
        w = -1;
        wb = 1'b0;
        evict_a = '0;
        for (int k = 0; k < 4; k++) begin
            if (m_valid[k] && m_line[k] == line_a) w = k;
        end
        if (w < 0) begin
            for (int k = 3; k >= 0; k--) begin
                if (!m_valid[k]) w = k;
            end
            if (w < 0) w = m_plru[2] ? (m_plru[0] ? 3 : 2) : (m_plru[1] ? 1 : 0);
            wb = m_valid[w] && m_dirty[w];
            evict_a = m_line[w];
            m_valid[w] = 1'b1;
            m_dirty[w] = 1'b0;
            m_line[w] = line_a;
        end
        m_dirty[w] = m_dirty[w] | write;
        if (w < 2) m_plru[2:1] = (w == 0) ? 2'b11 : 2'b10;
        else {m_plru[2], m_plru[0]} = (w == 2) ? 2'b01 : 2'b00;
    endtask

    task automatic test_fresh_read();
        check_value("req_rdy", req_rdy, 1'b1);
        check_value("mem_req_en", mem_req_en, 1'b0);
        log_base = mem.log_cmd.size();
        read_check(32'h0000_1238);
        check_request_count(1);
        check_request(0, cache_pkg::cmd_read, 32'h0000_1230);
        finish_test("fresh_read");
    endtask

    task automatic test_hit_timing();
        int cycles;
        log_base = mem.log_cmd.size();
        run_access(1'b1, 32'h0000_1238, 32'hCAFE_F00D, cycles);
        run_access(1'b0, 32'h0000_1238, '0, cycles);
        check_value("read_data", read_data, 32'hCAFE_F00D);
        check_value("hit_cycles", cycles, 3);
        check_request_count(0);
        finish_test("hit_timing");
    endtask

    task automatic test_write_miss();
        int cycles;
        log_base = mem.log_cmd.size();
        run_access(1'b1, 32'h2000_0454, 32'h1357_9BDF, cycles);
        check_request_count(1);
        check_request(0, cache_pkg::cmd_read, 32'h2000_0450);
        for (int k = 0; k < 4; k++) begin
            read_check(32'h2000_0450 + cache_pkg::addr_t'(4 * k));
        end
        finish_test("write_miss");
    endtask

    task automatic test_eviction();
        int cycles;
        bit wb;
        cache_pkg::addr_t ev, line_a;
        m_valid = '{default: 1'b0};
        m_dirty = '{default: 1'b0};
        m_plru = '0;
        for (int t = 1; t <= 5; t++) begin
            line_a = cache_pkg::addr_t'((t << 11) | (9 << 4));
            log_base = mem.log_cmd.size();
            model_access(t % 2 == 1, line_a, wb, ev);
            run_access(t % 2 == 1, line_a + 4, cache_pkg::word_t'($random(seed)), cycles);
            check_request_count(wb ? 2 : 1);
            if (wb) begin
                check_request(0, cache_pkg::cmd_write, ev);
                if (mem.log_data.size() > log_base) begin
                    check_value("mem_req_data", mem.log_data[log_base], expect_line(ev));
                end
            end
            check_request(wb ? 1 : 0, cache_pkg::cmd_read, line_a);
        end
        log_base = mem.log_cmd.size();
        model_access(1'b0, ev, wb, line_a);
        read_check(ev + 8);
        check_request(wb ? 1 : 0, cache_pkg::cmd_read, ev); // Evicted line misses again
        finish_test("eviction");
    endtask

    task automatic test_random_mix();
        int cycles;
        cache_pkg::addr_t a;
        stall_en = 1'b1;
        for (int i = 0; i < 200; i++) begin
            a = cache_pkg::addr_t'(((($random(seed) & 7) + 8) << 11) |
                                   ((($random(seed) & 3) + 16) << 4) | (($random(seed) & 3) << 2));
            if ($random(seed) & 1) begin
                run_access(1'b1, a, cache_pkg::word_t'($random(seed)), cycles);
            end else begin
                read_check(a);
            end
        end
        stall_en = 1'b0;
        finish_test("random_mix");
    endtask

    initial begin
        reset_n = 1'b0;
        rd_req = 1'b0;
        wr_req = 1'b0;
        addr = '0;
        wr_data = '0;
        stall_en = 1'b0;
        repeat (16) @(posedge clk);
        #2;
        reset_n = 1'b1;
        test_fresh_read();
        test_hit_timing();
        test_write_miss();
        test_eviction();
        test_random_mix();
        $display("Tests run 5, failed %0d, errors %0d", tests_failed, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: cache.f
hw/cache_pkg.sv
hw/cache_set_ram.sv
hw/cache_set_state.sv
hw/cache_lookup.sv
hw/cache_ctrl.sv
hw/cache_top.sv
tb/mem_model.sv
tb/cache_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the cache testbench with Verilator

verilator --binary --timing --assert -f cache.f --top-module cache_tb -o cache_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/cache_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "ERRORS FOUND" sim.log; then
    exit 1
fi
exit 0
